// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_elink_tx
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/elink_pkg.sv
/* shared code field encoding, K-character bytes and symbol width of the e-link transmitter
   only K28.1, K28.5 and K28.6 are known to the encoder */
`default_nettype none

package elink_pkg;

  // 8b/10b symbol width, fixed by the line code
  localparam int SYM_W = 10;

  // upper two bits of the 10-bit input word
  typedef enum logic [1:0] {
    CODE_DATA  = 2'b00, // byte goes out as a D-character
    CODE_SOP   = 2'b01, // start of packet
    CODE_EOP   = 2'b10, // end of packet
    CODE_COMMA = 2'b11  // comma, same as idle
  } code_t;

  // K-character bytes, HGF EDCBA
  localparam logic [7:0] K28_1 = 8'h3C; // sop marker
  localparam logic [7:0] K28_5 = 8'hBC; // comma and idle fill
  localparam logic [7:0] K28_6 = 8'hDC; // eop marker

endpackage

`default_nettype wire

// File: rtl/elink_serializer.sv
/* shifts each symbol out ELINK_WIDTH bits per clock, new symbol taken at the frame edge
   reset contents ignore reverse_10b; hold it stable across reset */
`timescale 1ns/1ns
`default_nettype none

module elink_serializer
  import elink_pkg::*;
#(
  parameter int ELINK_WIDTH = 2
) (
  input  logic                   getDataTrig,
  input  logic                   arst_n,
  input  logic                   swap_outbits,
  input  logic                   reverse_10b,
  enc_if.ser                     enc,
  output logic [ELINK_WIDTH-1:0] edata_out
);

  localparam int SLOTS = SYM_W / ELINK_WIDTH;
  localparam int CNT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(SLOTS - 1);
  localparam logic [SYM_W-1:0] K28_5_RDN = 10'b0101111100; // a in bit 0
  localparam logic [SYM_W-1:0] K28_5_RDP = 10'b1010000011;

  logic [CNT_W-1:0]       slot;
  logic                   boundary;  // last slot, shift register reloads
  logic [SYM_W-1:0]       pend;      // symbol waiting for the frame edge
  logic [SYM_W-1:0]       load_sym;
  logic [SYM_W-1:0]       load_rev;
  logic [SYM_W-1:0]       sreg;      // low group goes out next
  logic [ELINK_WIDTH-1:0] grp;
  logic [ELINK_WIDTH-1:0] grp_rev;

  assign boundary = (slot == LAST_SLOT);
  assign load_sym = enc.sym_stb ? enc.sym : pend; // bypass when it lands on the edge
  assign load_rev = {<<{load_sym}};               // msb first on the line
  assign grp      = sreg[ELINK_WIDTH-1:0];
  assign grp_rev  = {<<{grp}};

  always_ff @(posedge getDataTrig or negedge arst_n)
  begin
    if (!arst_n)
      slot <= '0;
    else
      slot <= boundary ? '0 : slot + 1'b1;
  end

  // reset values give K28.5 -, then K28.5 + in the second frame
  always_ff @(posedge getDataTrig or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pend <= K28_5_RDP;
      sreg <= K28_5_RDN;
    end
    else
    begin
      if (enc.sym_stb)
        pend <= enc.sym;
      if (boundary)
        sreg <= reverse_10b ? load_rev : load_sym;
      else
        sreg <= sreg >> ELINK_WIDTH;
    end
  end

  // output register, one cycle behind the shift register
  always_ff @(posedge getDataTrig or negedge arst_n)
  begin
    if (!arst_n)
      edata_out <= '0;
    else
      edata_out <= swap_outbits ? grp_rev : grp; // swap within the group only
  end

endmodule

`default_nettype wire

// File: rtl/elink_tx_ctrl.sv
/* frames the link in SYM_W/ELINK_WIDTH slots and samples one word per frame
   edata_in must be stable at the last slot edge, data_rdy low there means idle comma */
`timescale 1ns/1ns
`default_nettype none

module elink_tx_ctrl
  import elink_pkg::*;
#(
  parameter int ELINK_WIDTH = 2
) (
  input  logic       getDataTrig,
  input  logic       arst_n,
  input  logic [9:0] edata_in,
  input  logic       data_rdy,
  output logic       data_req,
  enc_if.ctrl        enc
);

  localparam int SLOTS = SYM_W / ELINK_WIDTH; // clocks per frame
  localparam int CNT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(SLOTS - 1);
  // request one slot ahead of sampling, every cycle for a one-slot frame
  localparam logic [CNT_W-1:0] REQ_SLOT = (SLOTS > 1) ? CNT_W'(SLOTS - 2) : '0;

  logic [CNT_W-1:0] slot;     // position inside the frame
  logic [CNT_W-1:0] slot_nxt;
  logic             sample;   // edge at the end of this slot takes the word
  code_t            code;
  logic [7:0]       sel_byte; // character chosen for the sampled word
  logic             sel_k;

  assign sample   = (slot == LAST_SLOT);
  assign slot_nxt = sample ? '0 : slot + 1'b1;
  assign code     = code_t'(edata_in[9:8]);

  // slot counter and request pulse
  always_ff @(posedge getDataTrig or negedge arst_n)
  begin
    if (!arst_n)
    begin
      slot     <= '0;
      data_req <= 1'b0;
    end
    else
    begin
      slot     <= slot_nxt;
      data_req <= (slot_nxt == REQ_SLOT); // registered, high during REQ_SLOT
    end
  end

  // code field to character
  always_comb
  begin
    sel_byte = K28_5; // idle fill
    sel_k    = 1'b1;
    if (data_rdy)
    begin
      case (code)
        CODE_DATA:  {sel_byte, sel_k} = {edata_in[7:0], 1'b0};
        CODE_SOP:   sel_byte = K28_1;
        CODE_EOP:   sel_byte = K28_6;
        default:    sel_byte = K28_5; // explicit comma
      endcase
    end
  end

  // strobe into the encoder, high during slot 0
  always_ff @(posedge getDataTrig or negedge arst_n)
  begin
    if (!arst_n)
      enc.enc_stb <= 1'b0;
    else
      enc.enc_stb <= sample;
  end

  // character held until the next frame
  always_ff @(posedge getDataTrig)
  begin
    if (sample)
    begin
      enc.tx_byte <= sel_byte;
      enc.tx_k    <= sel_k;
    end
  end

endmodule

`default_nettype wire

// File: rtl/elink_tx_top.sv
/* 8b/10b e-link transmitter, ELINK_WIDTH must be 1, 2, 5 or 10
   word on edata_in is sampled at the last slot edge, first bits leave one frame and one clock later */
`timescale 1ns/1ns
`default_nettype none

module elink_tx_top #(
  parameter int ELINK_WIDTH = 2 // bits per clock on edata_out
) (
  input  logic                   getDataTrig,
  input  logic                   arst_n,
  input  logic [9:0]             edata_in,    // {code, byte}
  input  logic                   data_rdy,    // level, word valid
  input  logic                   swap_outbits,
  input  logic                   reverse_10b,
  output logic                   data_req,    // one pulse per frame
  output logic [ELINK_WIDTH-1:0] edata_out
);

  enc_if enc_bus ();

  // framing, request and character select
  elink_tx_ctrl #(
    .ELINK_WIDTH (ELINK_WIDTH)
  ) elink_tx_ctrl_inst (
    .getDataTrig (getDataTrig),
    .arst_n      (arst_n),
    .edata_in    (edata_in),
    .data_rdy    (data_rdy),
    .data_req    (data_req),
    .enc         (enc_bus)
  );

  // symbol one cycle after the strobe
  enc_8b10b enc_8b10b_inst (
    .getDataTrig (getDataTrig),
    .arst_n      (arst_n),
    .enc         (enc_bus)
  );

  elink_serializer #(
    .ELINK_WIDTH (ELINK_WIDTH)
  ) elink_serializer_inst (
    .getDataTrig  (getDataTrig),
    .arst_n       (arst_n),
    .swap_outbits (swap_outbits),
    .reverse_10b  (reverse_10b),
    .enc          (enc_bus),
    .edata_out    (edata_out)
  );

endmodule

`default_nettype wire

// File: rtl/enc_8b10b.sv
/* 8b/10b encoder with running disparity, disparity starts negative after reset
   K flag always gives K28.y; y other than 1 or 6 is sent as K28.5 */
`timescale 1ns/1ns
`default_nettype none

module enc_8b10b
  import elink_pkg::*;
(
  input  logic getDataTrig,
  input  logic arst_n,
  enc_if.enc   enc
);

  logic [4:0]       x;         // EDCBA
  logic [2:0]       y;         // HGF
  logic [5:0]       six_n;     // abcdei for negative disparity, a in bit 5
  logic             six_flip;  // unbalanced sub-block, disparity flips
  logic             six_alt;   // positive disparity takes the complement
  logic [5:0]       six;
  logic             rd6;       // disparity after the 6b sub-block
  logic [3:0]       four_n;    // fghj, f in bit 3
  logic             four_flip;
  logic             four_alt;
  logic [3:0]       four;
  logic             use_a7;    // alternate D.x.7 to avoid a run of five
  logic [SYM_W-1:0] code_msb;  // abcdei fghj with a on the left
  logic [SYM_W-1:0] sym_nxt;   // a moved to bit 0, first on the line
  logic             rd_pos;    // running disparity, 1 is positive
  logic             rd_nxt;

  assign x = enc.tx_byte[4:0];
  assign y = enc.tx_byte[7:5];

  // 5b/6b
  always_comb
  begin
    case (x)
      5'd0:  six_n = 6'b100111;
      5'd1:  six_n = 6'b011101;
      5'd2:  six_n = 6'b101101;
      5'd3:  six_n = 6'b110001;
      5'd4:  six_n = 6'b110101;
      5'd5:  six_n = 6'b101001;
      5'd6:  six_n = 6'b011001;
      5'd7:  six_n = 6'b111000; // balanced but still alternates
      5'd8:  six_n = 6'b111001;
      5'd9:  six_n = 6'b100101;
      5'd10: six_n = 6'b010101;
      5'd11: six_n = 6'b110100;
      5'd12: six_n = 6'b001101;
      5'd13: six_n = 6'b101100;
      5'd14: six_n = 6'b011100;
      5'd15: six_n = 6'b010111;
      5'd16: six_n = 6'b011011;
      5'd17: six_n = 6'b100011;
      5'd18: six_n = 6'b010011;
      5'd19: six_n = 6'b110010;
      5'd20: six_n = 6'b001011;
      5'd21: six_n = 6'b101010;
      5'd22: six_n = 6'b011010;
      5'd23: six_n = 6'b111010;
      5'd24: six_n = 6'b110011;
      5'd25: six_n = 6'b100110;
      5'd26: six_n = 6'b010110;
      5'd27: six_n = 6'b110110;
      5'd28: six_n = 6'b001110;
      5'd29: six_n = 6'b101110;
      5'd30: six_n = 6'b011110;
      default: six_n = 6'b101011;
    endcase
    if (enc.tx_k)
      six_n = 6'b001111; // K.28, x ignored
    six_flip = ($countones(six_n) != 3);
    six_alt  = six_flip | (!enc.tx_k && x == 5'd7);
    six      = (rd_pos && six_alt) ? ~six_n : six_n;
    rd6      = rd_pos ^ six_flip;
  end

  // 3b/4b, selected by the disparity after the 6b part
  always_comb
  begin
    use_a7 = (y == 3'd7) &&
             (rd6 ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                  : (x == 5'd17 || x == 5'd18 || x == 5'd20));
    case (y)
      3'd0: four_n = 4'b1011;
      3'd1: four_n = 4'b1001;
      3'd2: four_n = 4'b0101;
      3'd3: four_n = 4'b1100; // balanced, alternates
      3'd4: four_n = 4'b1101;
      3'd5: four_n = 4'b1010;
      3'd6: four_n = 4'b0110;
      default: four_n = use_a7 ? 4'b0111 : 4'b1110;
    endcase
    four_flip = ($countones(four_n) != 2);
    four_alt  = four_flip | (y == 3'd3);
    four      = (rd6 && four_alt) ? ~four_n : four_n;
    if (enc.tx_k)
    begin
      if (y != 3'd1 && y != 3'd6)
        four_n = 4'b1010;               // K28.5 pattern
      four      = rd6 ? four_n : ~four_n; // K order is inverted vs data
      four_flip = 1'b0;
    end
    rd_nxt = rd6 ^ four_flip;
  end

  assign code_msb = {six, four};
  assign sym_nxt  = {<<{code_msb}}; // bit 0 becomes a

  // disparity and strobe
  always_ff @(posedge getDataTrig or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_pos      <= 1'b0; // negative
      enc.sym_stb <= 1'b0;
    end
    else
    begin
      enc.sym_stb <= enc.enc_stb;
      if (enc.enc_stb)
        rd_pos <= rd_nxt;
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (enc.enc_stb)
      enc.sym <= sym_nxt;
  end

endmodule

`default_nettype wire

// File: rtl/enc_if.sv
/* byte and symbol path between controller, encoder and serializer
   enc_stb and sym_stb are single-cycle strobes, nothing acknowledges them */
`timescale 1ns/1ns
`default_nettype none

interface enc_if
  import elink_pkg::*;
();

  logic [7:0]       tx_byte; // character to encode
  logic             tx_k;    // K-character flag
  logic             enc_stb; // tx_byte and tx_k valid this cycle
  logic [SYM_W-1:0] sym;     // encoded symbol, bit 0 is sent first
  logic             sym_stb; // sym just updated

  modport ctrl (output tx_byte, output tx_k, output enc_stb);

  modport enc (input tx_byte, input tx_k, input enc_stb, output sym, output sym_stb);

  modport ser (input sym, input sym_stb);

endinterface

`default_nettype wire

// File: verif/elink_tx_assert.sv
/* checks on the request pulse, encoded symbols and reset state of elink_tx_top
   assumes SYM_W divisible by ELINK_WIDTH with at least two slots per frame */
`timescale 1ns/1ns
`default_nettype none

module elink_tx_assert
  import elink_pkg::*;
#(
  parameter int ELINK_WIDTH = 2
) (
  input wire logic                   getDataTrig,
  input wire logic                   arst_n,
  input wire logic                   data_req,
  input wire logic                   sym_stb,
  input wire logic [SYM_W-1:0]       sym,
  input wire logic [ELINK_WIDTH-1:0] edata_out
);

  localparam int SLOTS = SYM_W / ELINK_WIDTH;

  // request is a single-cycle pulse
  req_pulse: assert property (@(posedge getDataTrig) disable iff (!arst_n)
    data_req |=> !data_req)
    else $error("data_req held longer than one cycle");

  // and it comes back exactly one frame later
  req_period: assert property (@(posedge getDataTrig) disable iff (!arst_n)
    data_req |-> ##SLOTS data_req)
    else $error("data_req not repeated after one frame");

  // 8b/10b symbols are balanced within one bit pair
  sym_ones: assert property (@(posedge getDataTrig) disable iff (!arst_n)
    sym_stb |-> ($countones(sym) >= 4 && $countones(sym) <= 6))
    else $error("symbol with bad ones count");

  reset_idle: assert property (@(posedge getDataTrig)
    !arst_n |-> (!data_req && !sym_stb && edata_out == '0))
    else $error("outputs active during reset");

endmodule

bind elink_tx_top elink_tx_assert #(
  .ELINK_WIDTH (ELINK_WIDTH)
) elink_tx_assert_inst (
  .getDataTrig (getDataTrig),
  .arst_n      (arst_n),
  .data_req    (data_req),
  .sym_stb     (enc_bus.sym_stb),
  .sym         (enc_bus.sym),
  .edata_out   (edata_out)
);

`default_nettype wire

// File: verif/tb_elink_tx.sv
/* e-link transmitter testbench with a reference 8b/10b model and a bit-stream collector
   frame alignment is taken from data_req and needs at least two slots per frame */
`timescale 1ns/1ns
`default_nettype none

module tb_elink_tx
  import elink_pkg::*;
();

  localparam int W       = 2;         // ELINK_WIDTH under test
  localparam int N       = SYM_W / W; // slots per frame
  localparam int REQ     = N - 2;     // slot where data_req is high
  localparam int TIMEOUT = 4 * N;     // cycles allowed per wait

  logic         getDataTrig;
  logic         arst_n;
  logic [9:0]   edata_in;
  logic         data_rdy;
  logic         swap_outbits;
  logic         reverse_10b;
  logic         data_req;
  logic [W-1:0] edata_out;

  logic [SYM_W-1:0] exp_q[$]; // reference symbols in line order
  logic [SYM_W-1:0] got_q[$]; // reassembled from edata_out
  int               n_err     = 0;
  int               n_checked = 0;
  int               n_tmo     = 0;
  int               seed      = 32'h48f9_01bf;
  logic             rd_model  = 1'b0; // reference running disparity starts negative

  // collector state
  int               tslot = -1; // unknown until first data_req
  int               gidx  = 0;
  logic             collecting = 1'b0;
  logic             rev_load   = 1'b0; // reverse_10b at the last load edge
  logic             swap_edge  = 1'b0; // swap_outbits at the last edge
  logic             cur_rev;
  logic [W-1:0]     grp;
  logic [SYM_W-1:0] acc;

  elink_tx_top #(
    .ELINK_WIDTH (W)
  ) elink_tx_top_inst (
    .getDataTrig  (getDataTrig),
    .arst_n       (arst_n),
    .edata_in     (edata_in),
    .data_rdy     (data_rdy),
    .swap_outbits (swap_outbits),
    .reverse_10b  (reverse_10b),
    .data_req     (data_req),
    .edata_out    (edata_out)
  );

  initial
  begin
    getDataTrig = 1'b0;
    forever #20 getDataTrig = ~getDataTrig; // 40 ns period
  end

  // RD- abcdei for D.x with a in bit 5
  function automatic logic [5:0] six_code(input logic [4:0] x);
    logic [5:0] t [32];
    t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001,
          6'b011001, 6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100,
          6'b001101, 6'b101100, 6'b011100, 6'b010111, 6'b011011, 6'b100011,
          6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
          6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110,
          6'b011110, 6'b101011};
    return t[x];
  endfunction

  // returns {new rd, symbol} where symbol bit 0 is a and goes first on the line
  function automatic logic [SYM_W:0] enc_ref(input logic [7:0] b, input logic k,
                                             input logic rd);
    logic [5:0]       s6;
    logic [3:0]       f4;
    logic [SYM_W-1:0] msb;
    logic [SYM_W-1:0] sym;
    logic             r6;
    logic             rn;
    logic             a7;
    logic [4:0]       x;
    logic [2:0]       y;
    x = b[4:0];
    y = b[7:5];
    if (k)
    begin
      case (b)
        K28_1:   msb = rd ? 10'b1100000110 : 10'b0011111001;
        K28_6:   msb = rd ? 10'b1100001001 : 10'b0011110110;
        default: msb = rd ? 10'b1100000101 : 10'b0011111010; // K28.5
      endcase
      rn = !rd; // K28.y flips disparity
    end
    else
    begin
      s6 = six_code(x);
      if (rd && ($countones(s6) != 3 || x == 5'd7))
        s6 = ~s6;
      r6 = rd ^ ($countones(s6) != 3);
      case (y)
        3'd0: f4 = 4'b1011;
        3'd1: f4 = 4'b1001;
        3'd2: f4 = 4'b0101;
        3'd3: f4 = 4'b1100;
        3'd4: f4 = 4'b1101;
        3'd5: f4 = 4'b1010;
        3'd6: f4 = 4'b0110;
        default: f4 = 4'b1110; // P7
      endcase
      a7 = (y == 3'd7) && ((!r6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                           (r6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
      if (a7)
        f4 = 4'b0111;
      if (r6 && ($countones(f4) != 2 || y == 3'd3 || y == 3'd7))
        f4 = ~f4;
      rn  = r6 ^ ($countones(f4) != 2);
      msb = {s6, f4};
    end
    for (int i = 0; i < SYM_W; i++)
      sym[i] = msb[SYM_W-1-i];
    return {rn, sym};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      n_err++;
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp_v, act_v);
    end
  endtask

  // returns on the falling edge that sees data_req
  task automatic wait_req();
    int cnt;
    cnt = 0;
    do
    begin
      @(negedge getDataTrig);
      cnt++;
    end
    while (!data_req && cnt < TIMEOUT);
    if (!data_req)
    begin
      n_err++;
      n_tmo++;
      $display("timeout: no data_req within %0d cycles at t=%0t", TIMEOUT, $time);
    end
  endtask

  // one frame of stimulus plus its reference symbol
  task automatic drive_frame(input logic rdy, input logic [9:0] word,
                             input logic rev, input logic swp);
    logic [7:0]   b;
    logic         k;
    logic [SYM_W:0] res;
    wait_req();
    edata_in     = word;
    data_rdy     = rdy;
    reverse_10b  = rev;
    swap_outbits = swp;
    b = K28_5; // idle
    k = 1'b1;
    if (rdy)
    begin
      case (code_t'(word[9:8]))
        CODE_DATA: {b, k} = {word[7:0], 1'b0};
        CODE_SOP:  b = K28_1;
        CODE_EOP:  b = K28_6;
        default:   b = K28_5;
      endcase
    end
    res      = enc_ref(b, k, rd_model);
    rd_model = res[SYM_W];
    exp_q.push_back(res[SYM_W-1:0]);
  endtask

  function automatic logic [9:0] rand_data();
    return {CODE_DATA, 8'($random(seed))};
  endfunction

  // swap and reverse levels seen at each edge to undo the reorder
  always @(posedge getDataTrig)
  begin
    swap_edge <= swap_outbits;
    if (tslot == N - 1)
      rev_load <= reverse_10b; // shift register reload edge
  end

  // stream collector with symbol groups arriving in slots 1 .. N-1 then 0
  always @(negedge getDataTrig)
  begin
    if (data_req)
      tslot = REQ;
    else if (tslot >= 0)
      tslot = (tslot == N - 1) ? 0 : tslot + 1;
    if (tslot >= 0)
    begin
      for (int i = 0; i < W; i++)
        grp[i] = swap_edge ? edata_out[W-1-i] : edata_out[i];
      if (tslot == 1)
      begin
        collecting = 1'b1;
        gidx       = 0;
        cur_rev    = rev_load;
      end
      if (collecting)
      begin
        acc[gidx*W +: W] = grp;
        gidx++;
        if (gidx == N)
        begin
          got_q.push_back(cur_rev ? {<<{acc}} : acc); // msb first when reversed
          gidx = 0;
        end
      end
    end
  end

  // compare process
  always @(negedge getDataTrig)
  begin
    while (got_q.size() > 0)
    begin
      if (exp_q.size() == 0)
      begin
        n_err++;
        $display("symbol received at t=%0t with nothing expected", $time);
        void'(got_q.pop_front());
      end
      else
      begin
        check_val("edata_out symbol", 32'(exp_q.pop_front()), 32'(got_q.pop_front()));
        n_checked++;
      end
    end
  end

  task automatic end_run();
    $display("done: %0d symbols checked, %0d errors, %0d timeouts",
             n_checked, n_err, n_tmo);
    if (n_err == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  endtask

  initial
  begin
    logic [SYM_W:0] res;
    logic [9:0]     words[$];
    int             widx;
    int             guard;
    int             target;
    arst_n       = 1'b0;
    edata_in     = '0;
    data_rdy     = 1'b0;
    swap_outbits = 1'b0;
    reverse_10b  = 1'b0;
    repeat (3)
    begin
      @(negedge getDataTrig);
      check_val("data_req", 32'd0, 32'(data_req));
      check_val("edata_out", 32'd0, 32'(edata_out));
    end
    arst_n = 1'b1;
    // second reset frame is K28.5 + from the serializer's pending register
    res = enc_ref(K28_5, 1'b1, 1'b1);
    exp_q.push_back(res[SYM_W-1:0]);

    repeat (4) drive_frame(1'b0, '0, 1'b0, 1'b0); // idle commas
    repeat (20) drive_frame(1'b1, rand_data(), 1'b0, 1'b0);
    // all codes with the byte ignored for K
    drive_frame(1'b1, {CODE_SOP, 8'h00}, 1'b0, 1'b0);
    repeat (3) drive_frame(1'b1, rand_data(), 1'b0, 1'b0);
    drive_frame(1'b1, {CODE_EOP, 8'h00}, 1'b0, 1'b0);
    drive_frame(1'b1, {CODE_COMMA, 8'h00}, 1'b0, 1'b0);
    repeat (8) drive_frame(1'b1, 10'($random(seed)), 1'b0, 1'b0);

    // word order must survive missed slots
    for (int i = 0; i < 12; i++)
      words.push_back(rand_data());
    widx = 0;
    for (int f = 0; f < 16; f++)
    begin
      if (f == 3 || f == 4 || f == 9 || f == 13)
        drive_frame(1'b0, words[widx], 1'b0, 1'b0); // word held back
      else
      begin
        drive_frame(1'b1, words[widx], 1'b0, 1'b0);
        widx++;
      end
    end

    repeat (6) drive_frame(1'b1, rand_data(), 1'b1, 1'b0); // msb first
    repeat (6) drive_frame(1'b1, rand_data(), 1'b0, 1'b1); // swapped groups
    repeat (4) drive_frame(1'b1, rand_data(), 1'b1, 1'b1);

    // idle until the pipeline has flushed every expected symbol
    target = n_checked + exp_q.size();
    guard  = 0;
    while (n_checked < target && n_tmo == 0 && guard < 8)
    begin
      drive_frame(1'b0, '0, 1'b0, 1'b0);
      guard++;
    end
    if (n_checked < target)
    begin
      n_err++;
      $display("stream stopped with %0d symbols still unchecked", target - n_checked);
    end
    end_run();
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/elink_pkg.sv
rtl/enc_if.sv
rtl/elink_tx_ctrl.sv
rtl/enc_8b10b.sv
rtl/elink_serializer.sv
rtl/elink_tx_top.sv
verif/elink_tx_assert.sv
verif/tb_elink_tx.sv
